/* common/prf_pkg.sv */
// -----------------------------------------------
// banked PRF package: register value and ROB index
// types, default sizes, highest-index pick function
// -----------------------------------------------

package prf_pkg;

    // -----------------------------------------------
    // types

    typedef logic [31:0] data_t;

    // 64-entry reorder buffer
    typedef logic [5:0] rob_idx_t;

    // -----------------------------------------------
    // default top-level sizes

    localparam int DEF_PR_COUNT   = 64;
    localparam int DEF_BANK_COUNT = 4;
    localparam int DEF_RR_COUNT   = 4;
    localparam int DEF_WR_COUNT   = 3;

    // widest request vector the pick function handles
    localparam int PICK_W = 16;

    // -----------------------------------------------
    // one-hot of the highest set request bit
    // scans lsb to msb so the msb has the last say
    function automatic logic [PICK_W-1:0] pick_highest(input logic [PICK_W-1:0] req);
        logic [PICK_W-1:0] grant;
        grant = '0;
        for (int i = 0; i < PICK_W; i++) begin
            if (req[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
            end
        end
        return grant;
    endfunction

endpackage

/* common/prf_wb_if.sv */
// -----------------------------------------------
// per-bank writeback stage from the writeback
// arbiter to the bank array and the top level
// -----------------------------------------------

interface prf_wb_if #(
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    parameter int UPPER_W    = $clog2(prf_pkg::DEF_PR_COUNT) - $clog2(prf_pkg::DEF_BANK_COUNT)
);
    import prf_pkg::*;

    // plain per-cycle strobe, no handshake
    logic [BANK_COUNT-1:0]              wb_valid;
    data_t [BANK_COUNT-1:0]             wb_data;
    logic [BANK_COUNT-1:0][UPPER_W-1:0] wb_upper_pr;
    rob_idx_t [BANK_COUNT-1:0]          wb_rob_idx;

    // writeback arbiter
    modport src (output wb_valid, output wb_data, output wb_upper_pr, output wb_rob_idx);

    // bank array write port
    modport dst (input wb_valid, input wb_data, input wb_upper_pr);

    // writeback bus outputs
    modport mon (input wb_valid, input wb_data, input wb_upper_pr, input wb_rob_idx);

endinterface

/* read_arb/prf_read_arbiter.sv */
// -----------------------------------------------
// read arbiter: bank steering, two read ports per
// bank, unacked request holding, registered indices
// -----------------------------------------------

module prf_read_arbiter #(
    parameter int PR_COUNT   = prf_pkg::DEF_PR_COUNT,
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    parameter int RR_COUNT   = prf_pkg::DEF_RR_COUNT,
    localparam int PR_W      = $clog2(PR_COUNT),
    localparam int BANK_W    = $clog2(BANK_COUNT),
    localparam int UPPER_W   = PR_W - BANK_W
) (
    input  logic                               CLK,
    input  logic                               nRST,

    // requests, one-cycle pulses
    input  logic [RR_COUNT-1:0]                rd_req_valid,
    input  logic [RR_COUNT-1:0][PR_W-1:0]      rd_req_pr,

    // ack and port used, per requester
    output logic [RR_COUNT-1:0]                rd_ack,
    output logic [RR_COUNT-1:0]                rd_port,

    // registered upper PR per bank and port
    output logic [BANK_COUNT-1:0][UPPER_W-1:0] read_idx0,
    output logic [BANK_COUNT-1:0][UPPER_W-1:0] read_idx1
);
    import prf_pkg::*;

    // kept requests that lost arbitration
    logic [RR_COUNT-1:0]                 unacked_valid;
    logic [RR_COUNT-1:0][PR_W-1:0]       unacked_pr;

    // merged requests
    logic [RR_COUNT-1:0]                 req_valid;
    logic [RR_COUNT-1:0][PR_W-1:0]       req_pr;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] req_by_bank;

    logic [BANK_COUNT-1:0][RR_COUNT-1:0] grant0;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] grant1;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] last_mask;
    logic [BANK_COUNT-1:0][RR_COUNT-1:0] next_mask;

    logic [RR_COUNT-1:0]                 next_ack;
    logic [RR_COUNT-1:0]                 next_port;
    logic [BANK_COUNT-1:0][UPPER_W-1:0]  next_idx0;
    logic [BANK_COUNT-1:0][UPPER_W-1:0]  next_idx1;

    // -----------------------------------------------
    // request merge and bank steering

    // a kept request wins over a new pulse from the same requester
    always_comb begin
        for (int r = 0; r < RR_COUNT; r++) begin
            req_valid[r] = unacked_valid[r] | rd_req_valid[r];
            req_pr[r]    = unacked_valid[r] ? unacked_pr[r] : rd_req_pr[r];
        end
    end

    always_comb begin
        req_by_bank = '0;
        for (int r = 0; r < RR_COUNT; r++) begin
            req_by_bank[req_pr[r][BANK_W-1:0]][r] = req_valid[r];
        end
    end

    // -----------------------------------------------
    // two-port selection per bank

    always_comb begin
        logic [PICK_W-1:0]   pick;
        logic [RR_COUNT-1:0] rest;
        logic [RR_COUNT-1:0] masked;
        for (int b = 0; b < BANK_COUNT; b++) begin
            // port 0 over all requests of the bank
            masked    = req_by_bank[b] & last_mask[b];
            pick      = pick_highest(PICK_W'((|masked) ? masked : req_by_bank[b]));
            grant0[b] = pick[RR_COUNT-1:0];

            // port 1 with the port 0 winner removed
            rest      = req_by_bank[b] & ~grant0[b];
            masked    = rest & last_mask[b];
            pick      = pick_highest(PICK_W'((|masked) ? masked : rest));
            grant1[b] = pick[RR_COUNT-1:0];
        end
    end

    // acks, port flags and next fairness masks
    always_comb begin
        next_ack  = '0;
        next_port = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            next_ack  |= grant0[b] | grant1[b];
            next_port |= grant1[b];
            // requesters below the port 1 winner go first next time
            for (int r = 0; r < RR_COUNT; r++) begin
                next_mask[b][r] = |(grant1[b] >> (r + 1));
            end
        end
    end

    // upper PR of each winner
    always_comb begin
        next_idx0 = '0;
        next_idx1 = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int r = 0; r < RR_COUNT; r++) begin
                if (grant0[b][r]) begin
                    next_idx0[b] = req_pr[r][PR_W-1:BANK_W];
                end
                if (grant1[b][r]) begin
                    next_idx1[b] = req_pr[r][PR_W-1:BANK_W];
                end
            end
        end
    end

    // -----------------------------------------------
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            unacked_valid <= '0;
            last_mask     <= '0;
            rd_ack        <= '0;
            rd_port       <= '0;
        end else begin
            unacked_valid <= req_valid & ~next_ack;
            last_mask     <= next_mask;
            rd_ack        <= next_ack;
            rd_port       <= next_port;
        end
    end

    always_ff @(posedge CLK) begin
        unacked_pr <= req_pr;
        read_idx0  <= next_idx0;
        read_idx1  <= next_idx1;
    end

endmodule

/* writeback/prf_wb_arbiter.sv */
// -----------------------------------------------
// writeback arbiter: bank steering, one write per
// bank, held losers, ready and writeback stage
// -----------------------------------------------

module prf_wb_arbiter #(
    parameter int PR_COUNT   = prf_pkg::DEF_PR_COUNT,
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    parameter int WR_COUNT   = prf_pkg::DEF_WR_COUNT,
    localparam int PR_W      = $clog2(PR_COUNT),
    localparam int BANK_W    = $clog2(BANK_COUNT),
    localparam int UPPER_W   = PR_W - BANK_W
) (
    input  logic                                 CLK,
    input  logic                                 nRST,

    input  logic [WR_COUNT-1:0]                  wb_valid,
    input  prf_pkg::data_t [WR_COUNT-1:0]        wb_data,
    input  logic [WR_COUNT-1:0][PR_W-1:0]        wb_pr,
    input  prf_pkg::rob_idx_t [WR_COUNT-1:0]     wb_rob_idx,
    output logic [WR_COUNT-1:0]                  wb_ready,

    prf_wb_if.src                                wb
);
    import prf_pkg::*;

    // losing writes held until granted
    logic [WR_COUNT-1:0]                 held_valid;
    data_t [WR_COUNT-1:0]                held_data;
    logic [WR_COUNT-1:0][PR_W-1:0]       held_pr;
    rob_idx_t [WR_COUNT-1:0]             held_rob;

    logic [WR_COUNT-1:0]                 req_valid;
    data_t [WR_COUNT-1:0]                req_data;
    logic [WR_COUNT-1:0][PR_W-1:0]       req_pr;
    rob_idx_t [WR_COUNT-1:0]             req_rob;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] req_by_bank;

    logic [BANK_COUNT-1:0][WR_COUNT-1:0] grant;
    logic [WR_COUNT-1:0]                 granted;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] last_mask;
    logic [BANK_COUNT-1:0][WR_COUNT-1:0] next_mask;

    // -----------------------------------------------
    // merge, steering and selection

    // new write ignored while a held one is pending
    always_comb begin
        req_by_bank = '0;
        for (int w = 0; w < WR_COUNT; w++) begin
            req_valid[w] = held_valid[w] | wb_valid[w];
            req_data[w]  = held_valid[w] ? held_data[w] : wb_data[w];
            req_pr[w]    = held_valid[w] ? held_pr[w] : wb_pr[w];
            req_rob[w]   = held_valid[w] ? held_rob[w] : wb_rob_idx[w];
            req_by_bank[req_pr[w][BANK_W-1:0]][w] = req_valid[w];
        end
    end

    always_comb begin
        logic [PICK_W-1:0]   pick;
        logic [WR_COUNT-1:0] masked;
        granted = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            masked   = req_by_bank[b] & last_mask[b];
            pick     = pick_highest(PICK_W'((|masked) ? masked : req_by_bank[b]));
            grant[b] = pick[WR_COUNT-1:0];
            granted |= grant[b];
            for (int w = 0; w < WR_COUNT; w++) begin
                next_mask[b][w] = |(grant[b] >> (w + 1));
            end
        end
    end

    assign wb_ready = ~held_valid;

    // -----------------------------------------------
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid  <= '0;
            last_mask   <= '0;
            wb.wb_valid <= '0;
        end else begin
            held_valid <= req_valid & ~granted;
            last_mask  <= next_mask;
            for (int b = 0; b < BANK_COUNT; b++) begin
                wb.wb_valid[b] <= |req_by_bank[b];
            end
        end
    end

    // winner payload onto the writeback stage
    always_ff @(posedge CLK) begin
        held_data <= req_data;
        held_pr   <= req_pr;
        held_rob  <= req_rob;
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int w = 0; w < WR_COUNT; w++) begin
                if (grant[b][w]) begin
                    wb.wb_data[b]     <= req_data[w];
                    wb.wb_upper_pr[b] <= req_pr[w][PR_W-1:BANK_W];
                    wb.wb_rob_idx[b]  <= req_rob[w];
                end
            end
        end
    end

endmodule

/* design/prf_bank_array.sv */
// -----------------------------------------------
// register storage per bank, two read ports and
// one write port, forward data register
// -----------------------------------------------

module prf_bank_array #(
    parameter int PR_COUNT   = prf_pkg::DEF_PR_COUNT,
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    localparam int PR_W      = $clog2(PR_COUNT),
    localparam int BANK_W    = $clog2(BANK_COUNT),
    localparam int UPPER_W   = PR_W - BANK_W,
    localparam int ENTRIES   = PR_COUNT / BANK_COUNT
) (
    input  logic                                  CLK,
    input  logic                                  nRST,

    input  logic [BANK_COUNT-1:0][UPPER_W-1:0]    read_idx0,
    input  logic [BANK_COUNT-1:0][UPPER_W-1:0]    read_idx1,
    prf_wb_if.dst                                 wb,

    output prf_pkg::data_t [BANK_COUNT-1:0][1:0]  rd_data,
    output prf_pkg::data_t [BANK_COUNT-1:0]       fwd_data
);
    import prf_pkg::*;

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank

        data_t mem [ENTRIES];

        // write at the edge that ends the writeback bus cycle
        always_ff @(posedge CLK) begin
            if (wb.wb_valid[b]) begin
                mem[wb.wb_upper_pr[b]] <= wb.wb_data[b];
            end
        end

        // combinational read from registered indices
        assign rd_data[b][0] = mem[read_idx0[b]];
        assign rd_data[b][1] = mem[read_idx1[b]];

        // value just written, one cycle after the bus
        always_ff @(posedge CLK or negedge nRST) begin
            if (!nRST) begin
                fwd_data[b] <= '0;
            end else if (wb.wb_valid[b]) begin
                fwd_data[b] <= wb.wb_data[b];
            end
        end

    end

endmodule

/* design/prf_top.sv */
// -----------------------------------------------
// banked physical register file top level
// -----------------------------------------------

module prf_top #(
    parameter int PR_COUNT   = prf_pkg::DEF_PR_COUNT,
    parameter int BANK_COUNT = prf_pkg::DEF_BANK_COUNT,
    parameter int RR_COUNT   = prf_pkg::DEF_RR_COUNT,
    parameter int WR_COUNT   = prf_pkg::DEF_WR_COUNT,
    localparam int PR_W      = $clog2(PR_COUNT),
    localparam int BANK_W    = $clog2(BANK_COUNT),
    localparam int UPPER_W   = PR_W - BANK_W
) (
    input  logic                                  CLK,
    input  logic                                  nRST,

    // register read
    input  logic [RR_COUNT-1:0]                   rd_req_valid,
    input  logic [RR_COUNT-1:0][PR_W-1:0]         rd_req_pr,
    output logic [RR_COUNT-1:0]                   rd_ack,
    output logic [RR_COUNT-1:0]                   rd_port,
    output prf_pkg::data_t [BANK_COUNT-1:0][1:0]  rd_data,

    // writeback in
    input  logic [WR_COUNT-1:0]                   wb_valid,
    input  prf_pkg::data_t [WR_COUNT-1:0]         wb_data,
    input  logic [WR_COUNT-1:0][PR_W-1:0]         wb_pr,
    input  prf_pkg::rob_idx_t [WR_COUNT-1:0]      wb_rob_idx,
    output logic [WR_COUNT-1:0]                   wb_ready,

    // writeback bus per bank
    output logic [BANK_COUNT-1:0]                 wb_bus_valid,
    output prf_pkg::data_t [BANK_COUNT-1:0]       wb_bus_data,
    output logic [BANK_COUNT-1:0][UPPER_W-1:0]    wb_bus_upper_pr,
    output prf_pkg::rob_idx_t [BANK_COUNT-1:0]    wb_bus_rob_idx,

    output prf_pkg::data_t [BANK_COUNT-1:0]       fwd_data
);

    logic [BANK_COUNT-1:0][UPPER_W-1:0] read_idx0;
    logic [BANK_COUNT-1:0][UPPER_W-1:0] read_idx1;

    prf_wb_if #(
        .BANK_COUNT (BANK_COUNT),
        .UPPER_W    (UPPER_W)
    ) wb_if ();

    prf_read_arbiter #(
        .PR_COUNT   (PR_COUNT),
        .BANK_COUNT (BANK_COUNT),
        .RR_COUNT   (RR_COUNT)
    ) u_read_arbiter (
        .CLK          (CLK),
        .nRST         (nRST),
        .rd_req_valid (rd_req_valid),
        .rd_req_pr    (rd_req_pr),
        .rd_ack       (rd_ack),
        .rd_port      (rd_port),
        .read_idx0    (read_idx0),
        .read_idx1    (read_idx1)
    );

    prf_wb_arbiter #(
        .PR_COUNT   (PR_COUNT),
        .BANK_COUNT (BANK_COUNT),
        .WR_COUNT   (WR_COUNT)
    ) u_wb_arbiter (
        .CLK        (CLK),
        .nRST       (nRST),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .wb_pr      (wb_pr),
        .wb_rob_idx (wb_rob_idx),
        .wb_ready   (wb_ready),
        .wb         (wb_if)
    );

    prf_bank_array #(
        .PR_COUNT   (PR_COUNT),
        .BANK_COUNT (BANK_COUNT)
    ) u_bank_array (
        .CLK       (CLK),
        .nRST      (nRST),
        .read_idx0 (read_idx0),
        .read_idx1 (read_idx1),
        .wb        (wb_if),
        .rd_data   (rd_data),
        .fwd_data  (fwd_data)
    );

    // writeback bus taken from the stage registers
    assign wb_bus_valid    = wb_if.wb_valid;
    assign wb_bus_data     = wb_if.wb_data;
    assign wb_bus_upper_pr = wb_if.wb_upper_pr;
    assign wb_bus_rob_idx  = wb_if.wb_rob_idx;

endmodule

/* bench/tb_clock.sv */
// --------------------------------------------------
// testbench clock and reset generator
// --------------------------------------------------

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // reset held low for a few rising edges
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

/* bench/tb_prf.sv */
// --------------------------------------------------
// banked PRF testbench: directed write and read
// conflicts, random traffic, shadow register model
// and assertion checks on the DUT outputs
// --------------------------------------------------

module tb_prf;
    import prf_pkg::*;

    localparam int PR_COUNT    = DEF_PR_COUNT;
    localparam int BANK_COUNT  = DEF_BANK_COUNT;
    localparam int RR_COUNT    = DEF_RR_COUNT;
    localparam int WR_COUNT    = DEF_WR_COUNT;
    localparam int PR_W        = $clog2(PR_COUNT);
    localparam int BANK_W      = $clog2(BANK_COUNT);
    localparam int UPPER_W     = PR_W - BANK_W;
    localparam int READ_LIMIT  = 2 * RR_COUNT;
    localparam int READ_TOTAL  = 200;
    localparam int PHASE_LIMIT = 1000;

    logic                               CLK;
    logic                               nRST;
    logic [RR_COUNT-1:0]                rd_req_valid;
    logic [RR_COUNT-1:0][PR_W-1:0]      rd_req_pr;
    logic [RR_COUNT-1:0]                rd_ack;
    logic [RR_COUNT-1:0]                rd_port;
    data_t [BANK_COUNT-1:0][1:0]        rd_data;
    logic [WR_COUNT-1:0]                wb_valid;
    data_t [WR_COUNT-1:0]               wb_data;
    logic [WR_COUNT-1:0][PR_W-1:0]      wb_pr;
    rob_idx_t [WR_COUNT-1:0]            wb_rob_idx;
    logic [WR_COUNT-1:0]                wb_ready;
    logic [BANK_COUNT-1:0]              wb_bus_valid;
    data_t [BANK_COUNT-1:0]             wb_bus_data;
    logic [BANK_COUNT-1:0][UPPER_W-1:0] wb_bus_upper_pr;
    rob_idx_t [BANK_COUNT-1:0]          wb_bus_rob_idx;
    data_t [BANK_COUNT-1:0]             fwd_data;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle       = 0;
    bit          timed_out   = 1'b0;
    int unsigned seed_draw;

    // expected register contents
    data_t shadow [PR_COUNT];

    // taken writes not yet on the bus, at most one per writer
    logic [WR_COUNT-1:0]           pend_valid;
    logic [WR_COUNT-1:0][PR_W-1:0] pend_pr;
    data_t                         pend_data [WR_COUNT];
    rob_idx_t                      pend_rob [WR_COUNT];
    int                            pend_cycle [WR_COUNT];
    logic [BANK_COUNT-1:0]         last_bus_valid;
    data_t [BANK_COUNT-1:0]        last_bus_data;

    // read requests waiting for their ack
    logic [RR_COUNT-1:0]           out_valid;
    logic [RR_COUNT-1:0][PR_W-1:0] out_pr;
    int                            out_cycle [RR_COUNT];

    tb_clock #(.PERIOD(20), .RESET_CYCLES(4)) u_clock (.CLK(CLK), .nRST(nRST));

    prf_top u_prf_top (
        .CLK             (CLK),
        .nRST            (nRST),
        .rd_req_valid    (rd_req_valid),
        .rd_req_pr       (rd_req_pr),
        .rd_ack          (rd_ack),
        .rd_port         (rd_port),
        .rd_data         (rd_data),
        .wb_valid        (wb_valid),
        .wb_data         (wb_data),
        .wb_pr           (wb_pr),
        .wb_rob_idx      (wb_rob_idx),
        .wb_ready        (wb_ready),
        .wb_bus_valid    (wb_bus_valid),
        .wb_bus_data     (wb_bus_data),
        .wb_bus_upper_pr (wb_bus_upper_pr),
        .wb_bus_rob_idx  (wb_bus_rob_idx),
        .fwd_data        (fwd_data)
    );

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        assert (actual === expected)
        else begin
            error_count++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_count++;
        assert (cond === 1'b1)
        else begin
            error_count++;
            $display("%s", what);
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        $display("timeout: %s", what);
    endtask

    always @(posedge CLK) cycle <= cycle + 1;

    // --------------------------------------------------
    // writeback bus and forward data monitor

    always @(negedge CLK) begin : write_monitor
        logic found;
        if (nRST === 1'b1) begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (last_bus_valid[b]) begin
                    compare_value($sformatf("fwd_data[%0d]", b), last_bus_data[b], fwd_data[b]);
                end
                if (wb_bus_valid[b]) begin
                    found = 1'b0;
                    for (int w = 0; w < WR_COUNT; w++) begin
                        if (!found && pend_valid[w] && int'(pend_pr[w][BANK_W-1:0]) == b
                            && pend_pr[w][PR_W-1:BANK_W] == wb_bus_upper_pr[b]
                            && pend_data[w] == wb_bus_data[b]
                            && pend_rob[w] == wb_bus_rob_idx[b]) begin
                            found         = 1'b1;
                            pend_valid[w] = 1'b0;
                        end
                    end
                    check_true(found, $sformatf("bus write in bank %0d matches no taken write", b));
                end
            end
            last_bus_valid = wb_bus_valid;
            last_bus_data  = wb_bus_data;
            for (int w = 0; w < WR_COUNT; w++) begin
                assert (!(pend_valid[w] && cycle - pend_cycle[w] >= WR_COUNT))
                else begin
                    error_count++;
                    $display("write of writer %0d never reached the bus in time", w);
                    pend_valid[w] = 1'b0;
                end
                // taken at the coming edge
                if (wb_valid[w] && wb_ready[w]) begin
                    pend_valid[w]     = 1'b1;
                    pend_pr[w]        = wb_pr[w];
                    pend_data[w]      = wb_data[w];
                    pend_rob[w]       = wb_rob_idx[w];
                    pend_cycle[w]     = cycle;
                    shadow[wb_pr[w]]  = wb_data[w];
                end
            end
        end
    end

    // --------------------------------------------------
    // read ack and data monitor

    always @(negedge CLK) begin : read_monitor
        int port_use [BANK_COUNT][2];
        int bank;
        int port;
        if (nRST === 1'b1) begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                port_use[b][0] = 0;
                port_use[b][1] = 0;
            end
            for (int r = 0; r < RR_COUNT; r++) begin
                if (rd_ack[r]) begin
                    check_true(out_valid[r], $sformatf("requester %0d acked with no request", r));
                    bank = int'(out_pr[r][BANK_W-1:0]);
                    port = int'(rd_port[r]);
                    port_use[bank][port]++;
                    compare_value($sformatf("rd_data[%0d][%0d]", bank, port),
                                  shadow[out_pr[r]], rd_data[bank][port]);
                    out_valid[r] = 1'b0;
                end
            end
            for (int b = 0; b < BANK_COUNT; b++) begin
                for (int p = 0; p < 2; p++) begin
                    check_true(port_use[b][p] <= 1,
                               $sformatf("bank %0d port %0d acked twice in one cycle", b, p));
                end
            end
            for (int r = 0; r < RR_COUNT; r++) begin
                assert (!(out_valid[r] && cycle - out_cycle[r] >= READ_LIMIT))
                else begin
                    error_count++;
                    $display("read of requester %0d was not acked in time", r);
                    out_valid[r] = 1'b0;
                end
                if (rd_req_valid[r] && !out_valid[r]) begin
                    out_valid[r] = 1'b1;
                    out_pr[r]    = rd_req_pr[r];
                    out_cycle[r] = cycle;
                end
            end
        end
    end

    // --------------------------------------------------
    // directed sequences

    task automatic wait_for_reset();
        int waited;
        waited = 0;
        while (nRST !== 1'b1 && !timed_out) begin
            @(negedge CLK);
            waited++;
            if (waited > 20) report_timeout("reset never released");
        end
    endtask

    task automatic check_reset_state();
        compare_value("rd_ack", 32'h0, 32'(rd_ack));
        compare_value("rd_port", 32'h0, 32'(rd_port));
        compare_value("wb_bus_valid", 32'h0, 32'(wb_bus_valid));
        compare_value("wb_ready", 32'((1 << WR_COUNT) - 1), 32'(wb_ready));
        for (int b = 0; b < BANK_COUNT; b++) begin
            compare_value($sformatf("fwd_data[%0d]", b), 32'h0, fwd_data[b]);
        end
    endtask

    // writers 1 and 2 both into bank 1, pr 5 and pr 9
    task automatic write_conflict();
        data_t d1;
        data_t d2;
        d1 = $urandom();
        d2 = $urandom();
        @(posedge CLK);
        wb_valid      <= 3'b110;
        wb_pr[1]      <= PR_W'(5);
        wb_data[1]    <= d1;
        wb_rob_idx[1] <= rob_idx_t'(11);
        wb_pr[2]      <= PR_W'(9);
        wb_data[2]    <= d2;
        wb_rob_idx[2] <= rob_idx_t'(12);
        @(posedge CLK);
        wb_valid <= '0;
        @(negedge CLK);
        compare_value("wb_bus_valid", 32'h2, 32'(wb_bus_valid));
        compare_value("wb_bus_upper_pr[1]", 32'(9 / BANK_COUNT), 32'(wb_bus_upper_pr[1]));
        compare_value("wb_bus_data[1]", d2, wb_bus_data[1]);
        compare_value("wb_ready[1]", 32'h0, 32'(wb_ready[1]));
        @(negedge CLK);
        compare_value("wb_bus_valid", 32'h2, 32'(wb_bus_valid));
        compare_value("wb_bus_upper_pr[1]", 32'(5 / BANK_COUNT), 32'(wb_bus_upper_pr[1]));
        compare_value("wb_bus_data[1]", d1, wb_bus_data[1]);
        compare_value("wb_ready[1]", 32'h1, 32'(wb_ready[1]));
    endtask

    // three writes to three banks in one cycle
    task automatic write_timing();
        int                    wr_pr [WR_COUNT];
        data_t                 d [WR_COUNT];
        logic [BANK_COUNT-1:0] exp_valid;
        int                    b;
        wr_pr     = '{16, 13, 14};
        exp_valid = '0;
        @(posedge CLK);
        for (int w = 0; w < WR_COUNT; w++) begin
            d[w]                 = $urandom();
            exp_valid[wr_pr[w] % BANK_COUNT] = 1'b1;
            wb_valid[w]         <= 1'b1;
            wb_pr[w]            <= PR_W'(wr_pr[w]);
            wb_data[w]          <= d[w];
            wb_rob_idx[w]       <= rob_idx_t'(20 + w);
        end
        @(posedge CLK);
        wb_valid <= '0;
        @(negedge CLK);
        compare_value("wb_bus_valid", 32'(exp_valid), 32'(wb_bus_valid));
        for (int w = 0; w < WR_COUNT; w++) begin
            b = wr_pr[w] % BANK_COUNT;
            compare_value($sformatf("wb_bus_data[%0d]", b), d[w], wb_bus_data[b]);
            compare_value($sformatf("wb_bus_upper_pr[%0d]", b), 32'(wr_pr[w] / BANK_COUNT),
                          32'(wb_bus_upper_pr[b]));
            compare_value($sformatf("wb_bus_rob_idx[%0d]", b), 32'(20 + w),
                          32'(wb_bus_rob_idx[b]));
        end
        @(negedge CLK);
        for (int w = 0; w < WR_COUNT; w++) begin
            b = wr_pr[w] % BANK_COUNT;
            compare_value($sformatf("fwd_data[%0d]", b), d[w], fwd_data[b]);
        end
    endtask

    // requesters 1, 2 and 3 all read bank 1
    task automatic read_conflict();
        @(posedge CLK);
        rd_req_valid <= 4'b1110;
        rd_req_pr[1] <= PR_W'(5);
        rd_req_pr[2] <= PR_W'(9);
        rd_req_pr[3] <= PR_W'(13);
        @(posedge CLK);
        rd_req_valid <= '0;
        @(negedge CLK);
        compare_value("rd_ack", 32'hc, 32'(rd_ack));
        compare_value("rd_port[3]", 32'h0, 32'(rd_port[3]));
        compare_value("rd_port[2]", 32'h1, 32'(rd_port[2]));
        @(negedge CLK);
        compare_value("rd_ack", 32'h2, 32'(rd_ack));
    endtask

    // --------------------------------------------------
    // random traffic

    // every register written once, in shuffled order
    task automatic random_writes();
        int                  order [PR_COUNT];
        int                  next;
        int                  j;
        int                  tmp;
        int                  waited;
        logic [WR_COUNT-1:0] offered;
        logic [WR_COUNT-1:0] taken;
        for (int i = 0; i < PR_COUNT; i++) order[i] = i;
        for (int i = PR_COUNT - 1; i > 0; i--) begin
            j        = int'($urandom() % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        next    = 0;
        waited  = 0;
        offered = '0;
        while ((next < PR_COUNT || offered != 0) && !timed_out) begin
            @(negedge CLK);
            taken = wb_valid & wb_ready;
            @(posedge CLK);
            for (int w = 0; w < WR_COUNT; w++) begin
                if (taken[w] || !offered[w]) begin
                    if (next < PR_COUNT) begin
                        wb_valid[w]   <= 1'b1;
                        wb_pr[w]      <= PR_W'(order[next]);
                        wb_data[w]    <= $urandom();
                        wb_rob_idx[w] <= rob_idx_t'($urandom());
                        offered[w]     = 1'b1;
                        next++;
                    end else begin
                        wb_valid[w] <= 1'b0;
                        offered[w]   = 1'b0;
                    end
                end
            end
            waited++;
            if (waited > PHASE_LIMIT) report_timeout("random writes did not finish");
        end
    endtask

    task automatic drain_writes();
        int waited;
        waited = 0;
        @(posedge CLK);
        while (pend_valid != 0 && !timed_out) begin
            @(posedge CLK);
            waited++;
            if (waited > PHASE_LIMIT) report_timeout("taken writes never reached the bus");
        end
    endtask

    task automatic random_reads();
        int                  issued;
        int                  waited;
        logic [RR_COUNT-1:0] busy;
        logic [RR_COUNT-1:0] pulse;
        issued = 0;
        waited = 0;
        busy   = '0;
        while ((issued < READ_TOTAL || busy != 0) && !timed_out) begin
            @(negedge CLK);
            busy = busy & ~rd_ack;
            @(posedge CLK);
            pulse = '0;
            for (int r = 0; r < RR_COUNT; r++) begin
                if (!busy[r] && issued < READ_TOTAL && $urandom() % 4 != 0) begin
                    pulse[r]      = 1'b1;
                    busy[r]       = 1'b1;
                    rd_req_pr[r] <= PR_W'($urandom());
                    issued++;
                end
            end
            rd_req_valid <= pulse;
            waited++;
            if (waited > PHASE_LIMIT) report_timeout("random reads were not all acked");
        end
    endtask

    task automatic finish_run();
        $display("checks %0d errors %0d timeouts %0d", check_count, error_count, int'(timed_out));
        if (error_count == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        seed_draw      = $urandom(32'h3a6d25a8);
        rd_req_valid   = '0;
        rd_req_pr      = '0;
        wb_valid       = '0;
        wb_data        = '0;
        wb_pr          = '0;
        wb_rob_idx     = '0;
        pend_valid     = '0;
        out_valid      = '0;
        last_bus_valid = '0;
        last_bus_data  = '0;
        for (int i = 0; i < PR_COUNT; i++) shadow[i] = '0;
        wait_for_reset();
        if (!timed_out) begin
            check_reset_state();
            write_conflict();
            write_timing();
            read_conflict();
            random_writes();
        end
        if (!timed_out) drain_writes();
        if (!timed_out) random_reads();
        finish_run();
    end

endmodule

/* build.f */
common/prf_pkg.sv
common/prf_wb_if.sv
read_arb/prf_read_arbiter.sv
writeback/prf_wb_arbiter.sv
design/prf_bank_array.sv
design/prf_top.sv
bench/tb_clock.sv
bench/tb_prf.sv

/* Makefile */
TOP = tb_prf
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
